//--- rtl/hist_pkg.sv
package hist_pkg;

   localparam int PIX_W      = 8;                  // bits per pixel
   localparam int NUM_BINS   = 256;                // bins per color
   localparam int NUM_COLORS = 4;                  // r, gr, gb, b
   localparam int DIM_W      = 13;                 // pairs per line or lines per frame
   localparam int REG_DATA_W = 16;                 // register write data
   localparam int COUNT_W    = 18;                 // one bin count

   typedef logic [PIX_W-1:0]              pix_t;
   typedef logic [$clog2(NUM_BINS)-1:0]   bin_idx_t;
   typedef logic [$clog2(NUM_COLORS)-1:0] color_t;    // {row parity, column parity}
   typedef logic [COUNT_W-1:0]            hist_count_t;
   typedef logic [DIM_W-1:0]              dim_t;

   localparam hist_count_t COUNT_MAX = '1;        // counts stick here

   typedef struct packed {
      color_t   color;                             // selects the counter
      bin_idx_t bin;                               // bin inside that counter
   } hist_addr_t;

   typedef enum logic [2:0] {
      REG_LEFT   = 3'd0,                           // window left, in pixels
      REG_TOP    = 3'd1,                           // window top, in lines
      REG_WIDTH  = 3'd2,
      REG_HEIGHT = 3'd3,
      REG_RADDR  = 3'd4                            // readout start address
   } reg_addr_e;

   typedef struct packed {
      dim_t left;                                  // pairs
      dim_t top;                                   // lines
      dim_t width;                                 // pairs
      dim_t height;                                // lines
   } win_cfg_t;

   typedef struct packed {
      logic     strobe;                            // one pixel for this color
      bin_idx_t bin;
   } bin_req_t;

   typedef struct packed {
      logic bank;                                  // bank being written this frame
      logic clear;                                 // zeroing the write bank
   } frame_ctl_t;

endpackage

//--- rtl/hist_config.sv
`timescale 1ns/1ps

module hist_config import hist_pkg::*; (
   input  logic                  pclk2x,
   input  logic                  rst_n,
   input  logic                  reg_wr,     // write strobe
   input  reg_addr_e             reg_addr,
   input  logic [REG_DATA_W-1:0] reg_wdata,
   output win_cfg_t              win_cfg     // to the window logic
);

   // window values are in pixels on the bus, always even
   // so bit 0 is dropped and the registers hold pairs

   always_ff @(posedge pclk2x or negedge rst_n) begin
      if (!rst_n) begin
         win_cfg <= '0;                                   // empty window until set
      end else if (reg_wr) begin
         case (reg_addr)
            REG_LEFT:   win_cfg.left   <= reg_wdata[DIM_W:1];
            REG_TOP:    win_cfg.top    <= reg_wdata[DIM_W:1];
            REG_WIDTH:  win_cfg.width  <= reg_wdata[DIM_W:1];
            REG_HEIGHT: win_cfg.height <= reg_wdata[DIM_W:1];
            default: ;                                    // raddr lives in readout
         endcase
      end
   end

endmodule

//--- rtl/pixel_window.sv
`timescale 1ns/1ps

module pixel_window import hist_pkg::*; #(
   parameter int CLEAR_LEN = NUM_BINS                     // cycles spent zeroing a bank
) (
   input  logic        pclk2x,
   input  logic        rst_n,
   input  logic        frame_run,                         // level, high for the frame
   input  logic        line_run,                          // level, high for a line
   input  logic [15:0] pix_pair,                          // low byte is the even column
   input  logic        pix_vld,
   input  logic [1:0]  bayer_phase,
   input  win_cfg_t    win_cfg,
   output bin_req_t    bin_req [NUM_COLORS],              // one request per color counter
   output frame_ctl_t  frame_ctl                          // shared by all counters
);

   localparam int CNT_W = $clog2(CLEAR_LEN + 1);

   typedef enum logic [1:0] {
      IDLE,                                               // between frames
      CLEAR,                                              // zeroing the new write bank
      ACTIVE                                              // counting pixels
   } state_e;

   state_e           state;
   logic             frame_run_d;
   logic             line_run_d;
   logic             frame_start;
   logic             line_start;
   logic             line_end;
   logic [CNT_W-1:0] clr_cnt;
   logic             bank;
   logic [1:0]       phase_q;
   dim_t             x_cnt;
   dim_t             x_cur;
   dim_t             y_cnt;
   logic [DIM_W:0]   x_end;
   logic [DIM_W:0]   y_end;
   logic             x_in;
   logic             y_in;
   logic             pair_ok;
   color_t           lo_color;
   color_t           hi_color;
   pix_t             lo_pix;
   pix_t             hi_pix;

   assign frame_start = frame_run & ~frame_run_d;          // first cycle of a frame
   assign line_start  = line_run & ~line_run_d;
   assign line_end    = ~line_run & line_run_d;

   always_ff @(posedge pclk2x or negedge rst_n) begin
      if (!rst_n) begin
         frame_run_d <= 1'b0;
         line_run_d  <= 1'b0;
      end else begin
         frame_run_d <= frame_run;
         line_run_d  <= line_run;
      end
   end

   // frame sequencer; bank flips as the clear begins
   always_ff @(posedge pclk2x or negedge rst_n) begin
      if (!rst_n) begin
         state   <= IDLE;
         clr_cnt <= '0;
         bank    <= 1'b0;
      end else if (frame_start) begin
         state   <= CLEAR;                                // restart even mid-frame
         clr_cnt <= '0;
         bank    <= ~bank;                                // old bank now readable
      end else begin
         case (state)
            CLEAR: begin
               clr_cnt <= clr_cnt + 1'b1;
               if (clr_cnt == CNT_W'(CLEAR_LEN - 1)) state <= ACTIVE;
            end
            ACTIVE: if (!frame_run) state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   assign frame_ctl.bank  = bank;
   assign frame_ctl.clear = (state == CLEAR);

   always_ff @(posedge pclk2x) begin
      if (frame_start) phase_q <= bayer_phase;            // held for the whole frame
   end

   // pair column within the line, row within the frame
   assign x_cur = line_start ? '0 : x_cnt;                 // pair may come with the edge

   always_ff @(posedge pclk2x or negedge rst_n) begin
      if (!rst_n) begin
         x_cnt <= '0;
         y_cnt <= '0;
      end else begin
         if (pix_vld && line_run) x_cnt <= x_cur + 1'b1;
         else if (line_start)     x_cnt <= '0;
         if (frame_start)         y_cnt <= '0;
         else if (line_end)       y_cnt <= y_cnt + 1'b1;
      end
   end

   // one extra bit so left+width past the dimension range still compares right
   assign x_end = {1'b0, win_cfg.left} + {1'b0, win_cfg.width};
   assign y_end = {1'b0, win_cfg.top} + {1'b0, win_cfg.height};
   assign x_in  = (x_cur >= win_cfg.left) && ({1'b0, x_cur} < x_end);
   assign y_in  = (y_cnt >= win_cfg.top) && ({1'b0, y_cnt} < y_end);

   assign pair_ok = pix_vld && line_run && (state == ACTIVE) && x_in && y_in;

   assign lo_pix   = pix_pair[7:0];
   assign hi_pix   = pix_pair[15:8];
   assign lo_color = {y_cnt[0] ^ phase_q[1],  phase_q[0]}; // even column
   assign hi_color = {y_cnt[0] ^ phase_q[1], ~phase_q[0]}; // odd column, other color

   // the two bytes never share a color, so each counter gets at most one
   always_ff @(posedge pclk2x or negedge rst_n) begin
      if (!rst_n) begin
         for (int c = 0; c < NUM_COLORS; c++) begin
            bin_req[c] <= '0;
         end
      end else begin
         for (int c = 0; c < NUM_COLORS; c++) begin
            bin_req[c].strobe <= pair_ok &&
                                 ((color_t'(c) == lo_color) || (color_t'(c) == hi_color));
            bin_req[c].bin    <= (color_t'(c) == lo_color) ? lo_pix : hi_pix;
         end
      end
   end

endmodule

//--- rtl/bin_counter.sv
`timescale 1ns/1ps

module bin_counter import hist_pkg::*; #(
   parameter int CLEAR_LEN = NUM_BINS
) (
   input  logic        pclk2x,
   input  logic        rst_n,
   input  bin_req_t    bin_req,                           // pixel bin for this color
   input  frame_ctl_t  frame_ctl,
   input  bin_idx_t    rd_bin,                            // readout bin
   input  logic        rd_en,
   output hist_count_t rd_count                           // one cycle after rd_en
);

   localparam int AW    = $bits(bin_idx_t) + 1;           // bank bit on top
   localparam int CNT_W = $clog2(CLEAR_LEN + 1);

   typedef logic [AW-1:0] mem_addr_t;

   hist_count_t      mem [2*NUM_BINS];                    // two banks of counts
   logic             take;
   logic [CNT_W-1:0] clr_idx;
   logic             clr_wr;
   logic             s1_vld;                              // read data back
   mem_addr_t        s1_addr;
   hist_count_t      rd_q;
   hist_count_t      s1_cnt;
   logic             s2_vld;                              // incremented count ready
   mem_addr_t        s2_addr;
   hist_count_t      s2_cnt;
   logic             wr_en;
   mem_addr_t        wr_addr;
   hist_count_t      wr_data;
   logic             wr_vld_q;                            // last cycle's write, for bypass
   mem_addr_t        wr_addr_q;
   hist_count_t      wr_data_q;

   assign take   = bin_req.strobe && !frame_ctl.clear;     // nothing counts while zeroing
   assign clr_wr = frame_ctl.clear && (clr_idx < NUM_BINS); // longer clear just idles

   // a read in cycle t misses the write of cycle t, which belongs to the
   // strobe two cycles earlier; take that value from the delayed write port
   assign s1_cnt = (wr_vld_q && (wr_addr_q == s1_addr)) ? wr_data_q : rd_q;

   // pipeline write has the port; a late write of the old frame beats a clear slot
   assign wr_en   = s2_vld || clr_wr;
   assign wr_addr = s2_vld ? s2_addr : {frame_ctl.bank, bin_idx_t'(clr_idx)};
   assign wr_data = s2_vld ? s2_cnt : '0;

   always_ff @(posedge pclk2x) begin
      if (wr_en) mem[wr_addr] <= wr_data;
      if (take)  rd_q <= mem[{frame_ctl.bank, bin_req.bin}];     // count side
      if (rd_en) rd_count <= mem[{~frame_ctl.bank, rd_bin}];     // finished frame
      s1_addr   <= {frame_ctl.bank, bin_req.bin};                // bank kept per item
      s2_addr   <= s1_addr;
      s2_cnt    <= (s1_cnt == COUNT_MAX) ? s1_cnt : s1_cnt + 1'b1; // saturate
      wr_addr_q <= wr_addr;
      wr_data_q <= wr_data;
   end

   always_ff @(posedge pclk2x or negedge rst_n) begin
      if (!rst_n) begin
         s1_vld   <= 1'b0;
         s2_vld   <= 1'b0;
         wr_vld_q <= 1'b0;
         clr_idx  <= '0;
      end else begin
         s1_vld   <= take;
         s2_vld   <= s1_vld;
         wr_vld_q <= wr_en;
         if (!frame_ctl.clear) clr_idx <= '0;             // clear cycle n zeroes bin n
         else                  clr_idx <= clr_idx + 1'b1;
      end
   end

endmodule

//--- rtl/hist_readout.sv
`timescale 1ns/1ps

module hist_readout import hist_pkg::*; (
   input  logic                  pclk2x,
   input  logic                  rst_n,
   input  logic                  reg_wr,
   input  reg_addr_e             reg_addr,
   input  logic [REG_DATA_W-1:0] reg_wdata,
   input  logic                  rd_next,                 // step to the next count
   output bin_idx_t              rd_bin,                  // to every counter
   output logic                  rd_en,
   input  hist_count_t           rd_count [NUM_COLORS],
   output hist_count_t           hist_data,
   output logic                  rd_valid                 // two cycles after the command
);

   hist_addr_t rd_ptr;                                     // address last read
   hist_addr_t nxt_addr;
   logic       load;
   logic       rd_cmd;
   color_t     col_d;                                      // color of the read in flight
   logic       vld_d;

   assign load   = reg_wr && (reg_addr == REG_RADDR);
   assign rd_cmd = load || rd_next;

   // address goes to the memories in the command cycle, pointer wraps at 1023
   assign nxt_addr = load ? hist_addr_t'(reg_wdata[$bits(hist_addr_t)-1:0])
                          : hist_addr_t'(rd_ptr + 1'b1);
   assign rd_bin   = nxt_addr.bin;
   assign rd_en    = rd_cmd;

   always_ff @(posedge pclk2x or negedge rst_n) begin
      if (!rst_n) begin
         rd_ptr   <= '0;
         vld_d    <= 1'b0;
         rd_valid <= 1'b0;
      end else begin
         if (rd_cmd) rd_ptr <= nxt_addr;
         vld_d    <= rd_cmd;                               // memory data out next cycle
         rd_valid <= vld_d;
      end
   end

   always_ff @(posedge pclk2x) begin
      if (rd_cmd) col_d <= nxt_addr.color;
      if (vld_d)  hist_data <= rd_count[col_d];           // pick the addressed color
   end

endmodule

//--- rtl/histogram_top.sv
`timescale 1ns/1ps

module histogram_top import hist_pkg::*; #(
   parameter int CLEAR_LEN = NUM_BINS
) (
   input  logic                  pclk2x,
   input  logic                  rst_n,
   input  logic                  frame_run,
   input  logic                  line_run,
   input  logic [15:0]           pix_pair,
   input  logic                  pix_vld,
   input  logic [1:0]            bayer_phase,
   input  logic                  reg_wr,
   input  reg_addr_e             reg_addr,
   input  logic [REG_DATA_W-1:0] reg_wdata,
   input  logic                  rd_next,
   output hist_count_t           hist_data,
   output logic                  rd_valid
);

   win_cfg_t    win_cfg;
   bin_req_t    bin_req  [NUM_COLORS];
   frame_ctl_t  frame_ctl;
   bin_idx_t    rd_bin;
   logic        rd_en;
   hist_count_t rd_count [NUM_COLORS];

   hist_config i_hist_config (
      .pclk2x    (pclk2x),
      .rst_n     (rst_n),
      .reg_wr    (reg_wr),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .win_cfg   (win_cfg)
   );

   pixel_window #(.CLEAR_LEN(CLEAR_LEN)) i_pixel_window (
      .pclk2x      (pclk2x),
      .rst_n       (rst_n),
      .frame_run   (frame_run),
      .line_run    (line_run),
      .pix_pair    (pix_pair),
      .pix_vld     (pix_vld),
      .bayer_phase (bayer_phase),
      .win_cfg     (win_cfg),
      .bin_req     (bin_req),
      .frame_ctl   (frame_ctl)
   );

   // one counter per bayer color, all on the same bank and clear
   for (genvar g = 0; g < NUM_COLORS; g++) begin : g_color
      bin_counter #(.CLEAR_LEN(CLEAR_LEN)) i_bin_counter (
         .pclk2x    (pclk2x),
         .rst_n     (rst_n),
         .bin_req   (bin_req[g]),
         .frame_ctl (frame_ctl),
         .rd_bin    (rd_bin),
         .rd_en     (rd_en),
         .rd_count  (rd_count[g])
      );
   end

   hist_readout i_hist_readout (
      .pclk2x    (pclk2x),
      .rst_n     (rst_n),
      .reg_wr    (reg_wr),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .rd_next   (rd_next),
      .rd_bin    (rd_bin),
      .rd_en     (rd_en),
      .rd_count  (rd_count),
      .hist_data (hist_data),
      .rd_valid  (rd_valid)
   );

endmodule

//--- verif/tb_histogram.sv
`timescale 1ns/1ps

module tb_histogram import hist_pkg::*; ;

   localparam int          CLEAR_CYC  = NUM_BINS;             // clear length given to the dut
   localparam int          ADDR_NUM   = NUM_COLORS * NUM_BINS;
   localparam int unsigned SAT        = (1 << $bits(hist_count_t)) - 1;
   localparam int          SAT_LINES  = 65;                   // 33 even rows push past SAT
   localparam int          SAT_PAIRS  = 8000;
   localparam int          PAT_CONST  = 0;
   localparam int          PAT_RANDOM = 1;
   localparam int          PAT_RUNS   = 2;                    // long runs of one value
   localparam int          RAND_SEED  = 32'h7acf_28e7;
   // every pair at its widest spacing, plus clears, reads and slack
   localparam int          WD_CYCLES  = 4 * (8*16 + 12*40 + 10*64 + SAT_LINES*SAT_PAIRS + 2*6*32)
                                        + 12 * (CLEAR_CYC + 16) + 6 * ADDR_NUM * 4 + 20000;

   logic                  pclk2x;
   logic                  rst_n;
   logic                  frame_run;
   logic                  line_run;
   logic [15:0]           pix_pair;
   logic                  pix_vld;
   logic [1:0]            bayer_phase;
   logic                  reg_wr;
   reg_addr_e             reg_addr;
   logic [REG_DATA_W-1:0] reg_wdata;
   logic                  rd_next;
   hist_count_t           hist_data;
   logic                  rd_valid;

   int unsigned cur_cnt  [ADDR_NUM];                          // model of the frame being sent
   int unsigned done_cnt [ADDR_NUM];                          // model of the finished frame
   logic [1:0]  frame_phase;
   int          win_left, win_top, win_width, win_height;     // in pairs and lines
   int          errors, test_errs, tests_run, tests_failed;

   histogram_top #(.CLEAR_LEN(CLEAR_CYC)) i_dut (
      .pclk2x      (pclk2x),
      .rst_n       (rst_n),
      .frame_run   (frame_run),
      .line_run    (line_run),
      .pix_pair    (pix_pair),
      .pix_vld     (pix_vld),
      .bayer_phase (bayer_phase),
      .reg_wr      (reg_wr),
      .reg_addr    (reg_addr),
      .reg_wdata   (reg_wdata),
      .rd_next     (rd_next),
      .hist_data   (hist_data),
      .rd_valid    (rd_valid)
   );

   initial begin
      pclk2x = 1'b0;
      forever #50 pclk2x = ~pclk2x;                          // 100 ns period
   end

   initial begin
      repeat (WD_CYCLES) @(posedge pclk2x);
      $display("timeout: run did not finish within %0d clock cycles", WD_CYCLES);
      $display("Regression failed");
      $finish;
   end

   task automatic check_count(input hist_count_t got, input hist_count_t exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t: %s count %0d, expected %0d", $time, what, got, exp);
         test_errs++;
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t: %s rd_valid %b, expected %b", $time, what, got, exp);
         test_errs++;
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      errors += test_errs;
      if (test_errs != 0) tests_failed++;
      $display("test %-10s %s, %0d errors", name, (test_errs == 0) ? "ok" : "FAILED", test_errs);
      test_errs = 0;
   endtask

   task automatic write_reg(input reg_addr_e addr, input int value);
      reg_wr    = 1'b1;
      reg_addr  = addr;
      reg_wdata = REG_DATA_W'(value);
      @(negedge pclk2x);
      reg_wr    = 1'b0;
   endtask

   task automatic set_window(input int left, input int top, input int width, input int height);
      win_left   = left;
      win_top    = top;
      win_width  = width;
      win_height = height;
      write_reg(REG_LEFT, 2 * left);                          // registers take pixels
      write_reg(REG_TOP, 2 * top);
      write_reg(REG_WIDTH, 2 * width);
      write_reg(REG_HEIGHT, 2 * height);
   endtask

   // reference model of window, bayer color and saturation for one pair
   task automatic model_pair(input int x, input int y, input logic [15:0] pair);
      int idx;
      if (x < win_left || x >= win_left + win_width) return;
      if (y < win_top || y >= win_top + win_height) return;
      for (int half = 0; half < 2; half++) begin
         idx = ((y & 1) ^ int'(frame_phase[1])) * 2 + (half ^ int'(frame_phase[0]));
         idx = idx * NUM_BINS + int'(pair[8*half +: 8]);
         if (cur_cnt[idx] < SAT) cur_cnt[idx]++;
      end
   endtask

   task automatic start_frame(input logic [1:0] phase);
      frame_phase = phase;
      bayer_phase = phase;
      frame_run   = 1'b1;
      done_cnt    = cur_cnt;                                  // banks swap here
      cur_cnt     = '{default: 0};
      repeat (CLEAR_CYC + 4) @(negedge pclk2x);               // clear has to finish
   endtask

   task automatic end_frame();
      repeat (4) @(negedge pclk2x);                           // last writes drain
      frame_run = 1'b0;
      repeat (2) @(negedge pclk2x);
   endtask

   task automatic send_lines(input int lines, input int pairs, input int mode,
                             input pix_t val, input int gap_min, input int gap_max);
      pix_t        run_val;
      int          run_left;
      int          gap;
      logic [15:0] pair;
      run_left = 0;
      run_val  = val;
      for (int y = 0; y < lines; y++) begin
         line_run = 1'b1;
         @(negedge pclk2x);
         for (int x = 0; x < pairs; x++) begin
            case (mode)
               PAT_CONST:  pair = {val, val};
               PAT_RANDOM: pair = 16'($urandom);
               default: begin
                  if (run_left == 0) begin
                     run_val  = pix_t'($urandom);
                     run_left = 1 + int'($urandom % 24);
                  end
                  run_left--;
                  pair = {run_val, run_val};                  // same bin in both counters
               end
            endcase
            model_pair(x, y, pair);
            pix_pair = pair;
            pix_vld  = 1'b1;
            @(negedge pclk2x);
            pix_vld  = 1'b0;
            gap = gap_min + int'($urandom % (gap_max - gap_min + 1));
            repeat (gap - 1) @(negedge pclk2x);
         end
         line_run = 1'b0;
         repeat (3) @(negedge pclk2x);                        // line blanking
      end
   endtask

   // load or step the pointer and expect the data exactly two cycles later
   task automatic read_one(input logic load, input int addr, input hist_count_t exp);
      string what;
      what = $sformatf("address %0d", addr);
      if (load) begin
         reg_wr    = 1'b1;
         reg_addr  = REG_RADDR;
         reg_wdata = REG_DATA_W'(addr);
      end else begin
         rd_next = 1'b1;
      end
      @(negedge pclk2x);
      reg_wr  = 1'b0;
      rd_next = 1'b0;
      check_flag(rd_valid, 1'b0, what);
      @(negedge pclk2x);
      check_flag(rd_valid, 1'b1, what);
      check_count(hist_data, exp, what);
   endtask

   task automatic read_all(input int start);
      int a;
      for (int i = 0; i < ADDR_NUM; i++) begin
         a = (start + i) % ADDR_NUM;                          // pointer wraps after 1023
         read_one(i == 0, a, hist_count_t'(done_cnt[a]));
      end
   endtask

   task automatic test_reset();
      repeat (20) begin
         check_flag(rd_valid, 1'b0, "idle after reset");
         @(negedge pclk2x);
      end
      finish_test("reset");
   endtask

   task automatic test_uniform();
      set_window(0, 0, 16, 8);
      start_frame(2'b00);
      send_lines(8, 16, PAT_CONST, 8'd7, 3, 3);
      end_frame();
      start_frame(2'b00);
      for (int a = 0; a < ADDR_NUM; a++) begin
         read_one(a == 0, a, (a % NUM_BINS == 7) ? hist_count_t'(64) : '0); // 4 rows x 16
      end
      end_frame();
      finish_test("uniform");
   endtask

   task automatic test_cropped();
      set_window(3, 2, 30, 8);
      start_frame(2'b01);
      send_lines(12, 40, PAT_RANDOM, 8'd0, 2, 4);
      end_frame();
      start_frame(2'b01);
      read_all(1000);
      end_frame();
      finish_test("cropped");
   endtask

   task automatic test_runs();
      set_window(0, 0, 64, 10);
      start_frame(2'b10);
      send_lines(10, 64, PAT_RUNS, 8'd0, 2, 2);               // strobe every 2 cycles
      end_frame();
      start_frame(2'b10);
      read_all(0);
      end_frame();
      finish_test("runs");
   endtask

   task automatic test_saturation();
      int rows;
      int exp;
      set_window(0, 0, SAT_PAIRS, SAT_LINES);
      start_frame(2'b00);
      send_lines(SAT_LINES, SAT_PAIRS, PAT_CONST, 8'ha5, 2, 2);
      end_frame();
      start_frame(2'b00);
      for (int c = 0; c < NUM_COLORS; c++) begin
         rows = (c < 2) ? (SAT_LINES + 1) / 2 : SAT_LINES / 2; // colors 0,1 sit on even rows
         exp  = (rows * SAT_PAIRS > int'(SAT)) ? int'(SAT) : rows * SAT_PAIRS;
         read_one(1'b1, c * NUM_BINS + 'ha5, hist_count_t'(exp));
      end
      read_all(0);
      end_frame();
      finish_test("saturation");
   endtask

   task automatic test_bank_swap();
      set_window(0, 0, 32, 6);
      start_frame(2'b00);
      send_lines(6, 32, PAT_RANDOM, 8'd0, 2, 3);              // frame a
      end_frame();
      start_frame(2'b11);
      read_all(0);                                            // a while b is running
      send_lines(6, 32, PAT_RUNS, 8'd0, 2, 3);                // frame b
      end_frame();
      start_frame(2'b00);
      read_all(0);                                            // b only, a is gone
      end_frame();
      finish_test("bank_swap");
   endtask

   initial begin
      void'($urandom(RAND_SEED));
      rst_n        = 1'b0;
      frame_run    = 1'b0;
      line_run     = 1'b0;
      pix_pair     = '0;
      pix_vld      = 1'b0;
      bayer_phase  = 2'b00;
      reg_wr       = 1'b0;
      reg_addr     = REG_LEFT;
      reg_wdata    = '0;
      rd_next      = 1'b0;
      frame_phase  = 2'b00;
      win_left     = 0;
      win_top      = 0;
      win_width    = 0;
      win_height   = 0;
      errors       = 0;
      test_errs    = 0;
      tests_run    = 0;
      tests_failed = 0;
      cur_cnt      = '{default: 0};
      done_cnt     = '{default: 0};
      repeat (16) @(negedge pclk2x);
      rst_n = 1'b1;
      @(negedge pclk2x);
      test_reset();
      test_uniform();
      test_cropped();
      test_runs();
      test_saturation();
      test_bank_swap();
      $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- src.f
rtl/hist_pkg.sv
rtl/hist_config.sv
rtl/pixel_window.sv
rtl/bin_counter.sv
rtl/hist_readout.sv
rtl/histogram_top.sv
verif/tb_histogram.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_histogram \
   --Mdir obj_dir -o tb_histogram > build.log 2>&1 &&
./obj_dir/tb_histogram > sim.log 2>&1 ||
{ echo "build or run error, see build.log and sim.log"; exit 1; }
grep -q "Regression passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
